// ==== hpp_pkg.sv ====
// shared cell layout, phase codes and fill constants for the HPP lattice-gas engine
`default_nettype none

package hpp_pkg;

    // ------------------------------
    // cell layout
    // ------------------------------
    localparam int CELL_W = 5;     // wall + four particle bits

    localparam int WALL_BIT = 4;
    localparam int N_BIT    = 3;
    localparam int E_BIT    = 2;
    localparam int S_BIT    = 1;
    localparam int W_BIT    = 0;

    // ------------------------------
    // phase codes
    // ------------------------------
    localparam int PHASE_W = 2;

    localparam logic [PHASE_W-1:0] PH_IDLE    = 2'd0;  // readout allowed
    localparam logic [PHASE_W-1:0] PH_FILL    = 2'd1;  // one site per cycle
    localparam logic [PHASE_W-1:0] PH_COLLIDE = 2'd2;
    localparam logic [PHASE_W-1:0] PH_PROP    = 2'd3;

    // ------------------------------
    // fill source
    // ------------------------------
    localparam logic [15:0] LFSR_SEED = 16'hace1;  // must be nonzero
    localparam logic [15:0] LFSR_TAPS = 16'hb400;  // Galois form, maximal length

    // interior site is populated only when lfsr[5:4] under this mask is zero
    localparam logic [1:0] DENSITY_MASK = 2'b11;

endpackage

`default_nettype wire

// ==== hpp_control_fsm.sv ====
// phase sequencer of the HPP engine; reset fill, then one generation per accepted frame_start
`timescale 1ns/100ps
`default_nettype none

module hpp_control_fsm (
    input  wire logic                         clk,
    input  wire logic                         reset,        // active low, synchronous
    input  wire logic                         fill_random,
    input  wire logic                         frame_start,
    input  wire logic                         pause,
    input  wire logic                         sweep_done,
    output logic      [hpp_pkg::PHASE_W-1:0]  phase,
    output logic                              sweep_start,
    output logic                              busy,
    output logic                              fill_random_q
);

    // state carries the phase code directly
    logic [hpp_pkg::PHASE_W-1:0] state;

    // ------------------------------
    // state register
    // ------------------------------
    always_ff @(posedge clk) begin
        if (!reset) begin
            state         <= hpp_pkg::PH_FILL;
            sweep_start   <= 1'b0;
            fill_random_q <= fill_random;   // last reset cycle wins
        end else begin
            sweep_start <= 1'b0;
            case (state)
                hpp_pkg::PH_FILL: begin
                    if (sweep_done) begin
                        state <= hpp_pkg::PH_IDLE;
                    end
                end
                hpp_pkg::PH_IDLE: begin
                    if (frame_start && !pause) begin
                        state       <= hpp_pkg::PH_COLLIDE;
                        sweep_start <= 1'b1;
                    end
                end
                hpp_pkg::PH_COLLIDE: begin
                    if (sweep_done) begin
                        state       <= hpp_pkg::PH_PROP;
                        sweep_start <= 1'b1;
                    end
                end
                default: begin              // propagation
                    if (sweep_done) begin
                        state <= hpp_pkg::PH_IDLE;
                    end
                end
            endcase
        end
    end

    // the start cycle only rewinds the counter and gives the rows no work
    assign phase = sweep_start ? hpp_pkg::PH_IDLE : state;
    assign busy  = (state != hpp_pkg::PH_IDLE);

    // ------------------------------
    // checks
    // ------------------------------

    // a pulse while busy never starts another generation
    a_no_restart_while_busy : assert property (
        @(posedge clk) disable iff (!reset)
        (busy && frame_start) |=> !(sweep_start && state == hpp_pkg::PH_COLLIDE)
    );

endmodule

`default_nettype wire

// ==== hpp_sweep_counter.sv ====
// site counter for the grid sweeps; rows run fastest in fill, columns alone otherwise
`timescale 1ns/100ps
`default_nettype none

module hpp_sweep_counter #(
    parameter int ROWS = 8,
    parameter int COLS = 12
) (
    input  wire logic                         clk,
    input  wire logic                         reset,
    input  wire logic [hpp_pkg::PHASE_W-1:0]  phase,
    input  wire logic                         sweep_start,
    output logic      [$clog2(COLS)-1:0]      col,
    output logic      [$clog2(ROWS)-1:0]      row,
    output logic                              sweep_done
);

    localparam int COL_W = $clog2(COLS);
    localparam int ROW_W = $clog2(ROWS);

    logic last_col;
    logic last_row;

    assign last_col = (col == COL_W'(COLS - 1));
    assign last_row = (row == ROW_W'(ROWS - 1));

    always_ff @(posedge clk) begin
        if (!reset || sweep_start) begin
            col <= '0;
            row <= '0;
        end else if (phase == hpp_pkg::PH_FILL) begin
            if (last_row) begin
                row <= '0;
                col <= last_col ? '0 : col + 1'b1;  // wraps to 0 after the last site
            end else begin
                row <= row + 1'b1;
            end
        end else if (phase != hpp_pkg::PH_IDLE) begin
            col <= last_col ? '0 : col + 1'b1;
        end
    end

    // idle and start cycles never flag an end
    assign sweep_done = (phase == hpp_pkg::PH_FILL) ? (last_row && last_col)
                                                    : ((phase != hpp_pkg::PH_IDLE) && last_col);

    a_col_range : assert property (@(posedge clk) disable iff (!reset) int'(col) < COLS);
    a_row_range : assert property (@(posedge clk) disable iff (!reset) int'(row) < ROWS);

endmodule

`default_nettype wire

// ==== hpp_fill_source.sv ====
// initial cell value per site for the reset fill; border walls plus an optional LFSR particle pattern
`timescale 1ns/100ps
`default_nettype none

module hpp_fill_source #(
    parameter int ROWS = 8,
    parameter int COLS = 12
) (
    input  wire logic                         clk,
    input  wire logic                         reset,
    input  wire logic [hpp_pkg::PHASE_W-1:0]  phase,
    input  wire logic                         fill_random_q,
    input  wire logic [$clog2(ROWS)-1:0]      row,
    input  wire logic [$clog2(COLS)-1:0]      col,
    output logic      [hpp_pkg::CELL_W-1:0]   fill_cell
);

    logic [15:0] lfsr;
    logic        border;
    logic        dense;     // site gets particles

    // steps once per random fill cycle, so the pattern is timing independent
    always_ff @(posedge clk) begin
        if (!reset) begin
            lfsr <= hpp_pkg::LFSR_SEED;
        end else if (phase == hpp_pkg::PH_FILL && fill_random_q) begin
            lfsr <= (lfsr >> 1) ^ (lfsr[0] ? hpp_pkg::LFSR_TAPS : 16'h0000);
        end
    end

    assign border = (row == '0) || (int'(row) == ROWS - 1)
                 || (col == '0) || (int'(col) == COLS - 1);
    assign dense  = fill_random_q && ((lfsr[5:4] & hpp_pkg::DENSITY_MASK) == 2'b00);

    always_comb begin
        fill_cell = '0;
        if (border) begin
            fill_cell[hpp_pkg::WALL_BIT] = 1'b1;
        end else if (dense) begin
            fill_cell[3:0] = lfsr[3:0];     // n, e, s, w in bit order
        end
    end

endmodule

`default_nettype wire

// ==== hpp_row_pe.sv ====
// one grid row of the HPP engine; stores COLS cells and does fill, collision, propagation and readout
`timescale 1ns/100ps
`default_nettype none

module hpp_row_pe #(
    parameter int ROWS   = 8,
    parameter int COLS   = 12,
    parameter int ROW_ID = 0
) (
    input  wire logic                         clk,
    input  wire logic                         reset,
    input  wire logic [hpp_pkg::PHASE_W-1:0]  phase,
    input  wire logic [$clog2(COLS)-1:0]      col,
    input  wire logic [$clog2(ROWS)-1:0]      row,
    input  wire logic [hpp_pkg::CELL_W-1:0]   fill_cell,
    input  wire logic                         s_from_above,
    input  wire logic                         n_from_below,
    output logic                              n_out,
    output logic                              s_out,
    input  wire logic [$clog2(ROWS)-1:0]      read_row,
    input  wire logic [$clog2(COLS)-1:0]      read_col,
    input  wire logic [hpp_pkg::CELL_W-1:0]   read_in,
    output logic      [hpp_pkg::CELL_W-1:0]   read_out
);

    localparam int COL_W = $clog2(COLS);
    localparam int ROW_W = $clog2(ROWS);

    logic [hpp_pkg::CELL_W-1:0] cells [COLS];
    logic [hpp_pkg::CELL_W-1:0] cur;
    logic [hpp_pkg::CELL_W-1:0] collided;
    logic [hpp_pkg::CELL_W-1:0] moved;
    logic [COL_W-1:0]           next_col;
    logic                       prev_east;   // east bit of col-1 before its update
    logic                       fill_we;

    assign cur      = cells[col];
    assign n_out    = cur[hpp_pkg::N_BIT];
    assign s_out    = cur[hpp_pkg::S_BIT];
    assign next_col = (int'(col) == COLS - 1) ? col : col + 1'b1;
    assign fill_we  = (phase == hpp_pkg::PH_FILL) && (row == ROW_W'(ROW_ID));

    // ------------------------------
    // collision rule
    // ------------------------------
    always_comb begin
        collided = cur;
        if (cur[hpp_pkg::WALL_BIT]) begin
            // bounce straight back
            collided[hpp_pkg::N_BIT] = cur[hpp_pkg::S_BIT];
            collided[hpp_pkg::S_BIT] = cur[hpp_pkg::N_BIT];
            collided[hpp_pkg::E_BIT] = cur[hpp_pkg::W_BIT];
            collided[hpp_pkg::W_BIT] = cur[hpp_pkg::E_BIT];
        end else if (cur == 5'b01010) begin
            collided = 5'b00101;        // n+s turns into e+w
        end else if (cur == 5'b00101) begin
            collided = 5'b01010;
        end
    end

    // ------------------------------
    // propagation gather
    // ------------------------------
    always_comb begin
        moved                    = '0;
        moved[hpp_pkg::WALL_BIT] = cur[hpp_pkg::WALL_BIT];
        moved[hpp_pkg::N_BIT]    = n_from_below;
        moved[hpp_pkg::S_BIT]    = s_from_above;
        moved[hpp_pkg::E_BIT]    = (col == '0) ? 1'b0 : prev_east;
        moved[hpp_pkg::W_BIT]    = (int'(col) == COLS - 1) ? 1'b0
                                                           : cells[next_col][hpp_pkg::W_BIT];
    end

    always_ff @(posedge clk) begin
        if (reset) begin            // no writes while reset is held
            case (phase)
                hpp_pkg::PH_FILL: begin
                    if (fill_we) begin
                        cells[col] <= fill_cell;
                    end
                end
                hpp_pkg::PH_COLLIDE: cells[col] <= collided;
                hpp_pkg::PH_PROP: begin
                    cells[col] <= moved;
                    prev_east  <= cur[hpp_pkg::E_BIT];
                end
                default: ;
            endcase
        end
    end

    // readout chain, only the addressed row adds its cell
    assign read_out = (read_row == ROW_W'(ROW_ID)) ? (read_in | cells[read_col]) : read_in;

    // fill happens once; once the grid is live the fill phase never comes back
    a_no_late_fill : assert property (
        @(posedge clk) disable iff (!reset)
        (phase != hpp_pkg::PH_FILL) |=> (phase != hpp_pkg::PH_FILL)
    );

endmodule

`default_nettype wire

// ==== hpp_automaton.sv ====
// top level of the HPP lattice-gas engine; sequencer, sweep counter, fill source and a column of rows
`timescale 1ns/100ps
`default_nettype none

module hpp_automaton #(
    parameter int ROWS = 8,
    parameter int COLS = 12
) (
    input  wire logic                         clk,
    input  wire logic                         reset,
    input  wire logic                         fill_random,
    input  wire logic                         frame_start,
    input  wire logic                         pause,
    input  wire logic [$clog2(ROWS)-1:0]      read_row,
    input  wire logic [$clog2(COLS)-1:0]      read_col,
    output logic      [hpp_pkg::CELL_W-1:0]   cell_out,
    output logic                              busy
);

    localparam int COL_W = $clog2(COLS);
    localparam int ROW_W = $clog2(ROWS);

    logic [hpp_pkg::PHASE_W-1:0] phase;
    logic                        sweep_start;
    logic                        sweep_done;
    logic                        fill_random_q;
    logic [COL_W-1:0]            col;
    logic [ROW_W-1:0]            row;
    logic [hpp_pkg::CELL_W-1:0]  fill_cell;

    // ------------------------------
    // neighbor and readout chains
    // ------------------------------
    logic [ROWS:0]              s_line;             // s_line[r] feeds row r from above
    logic [ROWS:0]              n_line;             // n_line[r+1] feeds row r from below
    logic [hpp_pkg::CELL_W-1:0] read_line [ROWS+1];

    assign s_line[0]     = 1'b0;    // top edge
    assign n_line[ROWS]  = 1'b0;    // bottom edge
    assign read_line[0]  = '0;
    assign cell_out      = read_line[ROWS];

    hpp_control_fsm u_fsm (
        .clk(clk), .reset(reset), .fill_random(fill_random), .frame_start(frame_start),
        .pause(pause), .sweep_done(sweep_done), .phase(phase), .sweep_start(sweep_start),
        .busy(busy), .fill_random_q(fill_random_q)
    );

    hpp_sweep_counter #(.ROWS(ROWS), .COLS(COLS)) u_counter (
        .clk(clk), .reset(reset), .phase(phase), .sweep_start(sweep_start),
        .col(col), .row(row), .sweep_done(sweep_done)
    );

    hpp_fill_source #(.ROWS(ROWS), .COLS(COLS)) u_fill (
        .clk(clk), .reset(reset), .phase(phase), .fill_random_q(fill_random_q),
        .row(row), .col(col), .fill_cell(fill_cell)
    );

    for (genvar r = 0; r < ROWS; r++) begin : g_row
        hpp_row_pe #(.ROWS(ROWS), .COLS(COLS), .ROW_ID(r)) u_row (
            .clk(clk), .reset(reset), .phase(phase), .col(col), .row(row),
            .fill_cell(fill_cell),
            .s_from_above(s_line[r]), .n_from_below(n_line[r+1]),
            .n_out(n_line[r]), .s_out(s_line[r+1]),
            .read_row(read_row), .read_col(read_col),
            .read_in(read_line[r]), .read_out(read_line[r+1])
        );
    end

endmodule

`default_nettype wire

// ==== tb_hpp_model.svh ====
// reference model of the HPP grid for the testbench; included inside the testbench module
`ifndef TB_HPP_MODEL_SVH
`define TB_HPP_MODEL_SVH

logic [hpp_pkg::CELL_W-1:0] model_grid [ROWS][COLS];
logic [31:0]                lcg_state = 32'hd72d;   // spot check picker

// ------------------------------
// number sources
// ------------------------------
function automatic logic [15:0] lfsr_next(input logic [15:0] v);
    return v[0] ? ((v >> 1) ^ hpp_pkg::LFSR_TAPS) : (v >> 1);
endfunction

function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
endfunction

// walls on the border, particles inside only in random mode
task automatic model_fill(input logic random_mode);
    logic [15:0] lfsr;
    lfsr = hpp_pkg::LFSR_SEED;
    for (int c = 0; c < COLS; c++) begin
        for (int r = 0; r < ROWS; r++) begin    // rows fastest, as the fill sweep
            model_grid[r][c] = '0;
            if (r == 0 || r == ROWS - 1 || c == 0 || c == COLS - 1) begin
                model_grid[r][c][hpp_pkg::WALL_BIT] = 1'b1;
            end else if (random_mode && (lfsr[5:4] & hpp_pkg::DENSITY_MASK) == 2'b00) begin
                model_grid[r][c][3:0] = lfsr[3:0];
            end
            if (random_mode) begin
                lfsr = lfsr_next(lfsr);
            end
        end
    end
endtask

// ------------------------------
// generation rules
// ------------------------------
function automatic logic [hpp_pkg::CELL_W-1:0] collide(input logic [hpp_pkg::CELL_W-1:0] c);
    if (c[hpp_pkg::WALL_BIT]) begin
        return {1'b1, c[hpp_pkg::S_BIT], c[hpp_pkg::W_BIT], c[hpp_pkg::N_BIT], c[hpp_pkg::E_BIT]};
    end
    if (c == 5'b01010) begin
        return 5'b00101;    // head-on n/s pair turns sideways
    end
    if (c == 5'b00101) begin
        return 5'b01010;
    end
    return c;
endfunction

task automatic model_generation();
    logic [hpp_pkg::CELL_W-1:0] hit [ROWS][COLS];
    for (int r = 0; r < ROWS; r++) begin
        for (int c = 0; c < COLS; c++) begin
            hit[r][c] = collide(model_grid[r][c]);
        end
    end
    for (int r = 0; r < ROWS; r++) begin
        for (int c = 0; c < COLS; c++) begin
            model_grid[r][c] = '0;
            model_grid[r][c][hpp_pkg::WALL_BIT] = hit[r][c][hpp_pkg::WALL_BIT];
            if (r < ROWS - 1) model_grid[r][c][hpp_pkg::N_BIT] = hit[r+1][c][hpp_pkg::N_BIT];
            if (r > 0)        model_grid[r][c][hpp_pkg::S_BIT] = hit[r-1][c][hpp_pkg::S_BIT];
            if (c > 0)        model_grid[r][c][hpp_pkg::E_BIT] = hit[r][c-1][hpp_pkg::E_BIT];
            if (c < COLS - 1) model_grid[r][c][hpp_pkg::W_BIT] = hit[r][c+1][hpp_pkg::W_BIT];
        end
    end
endtask

function automatic int model_particles();
    int total;
    total = 0;
    for (int r = 0; r < ROWS; r++) begin
        for (int c = 0; c < COLS; c++) begin
            total += $countones(model_grid[r][c][3:0]);
        end
    end
    return total;
endfunction

`endif

// ==== tb_hpp_automaton.sv ====
// directed testbench for the HPP engine; checks fill, generations and frame gating against a model
`timescale 1ns/100ps
`default_nettype none

module tb_hpp_automaton;

    localparam int ROWS       = 8;
    localparam int COLS       = 12;
    localparam int ROW_W      = $clog2(ROWS);
    localparam int COL_W      = $clog2(COLS);
    localparam int WAIT_LIMIT = 4 * ROWS * COLS;    // cycles per busy wait

    logic                       clk;
    logic                       reset;
    logic                       fill_random;
    logic                       frame_start;
    logic                       pause;
    logic [ROW_W-1:0]           read_row;
    logic [COL_W-1:0]           read_col;
    logic [hpp_pkg::CELL_W-1:0] cell_out;
    logic                       busy;
    int                         errors;
    int                         checks;

    `include "tb_hpp_model.svh"

    hpp_automaton #(.ROWS(ROWS), .COLS(COLS)) uut (
        .clk(clk), .reset(reset), .fill_random(fill_random), .frame_start(frame_start),
        .pause(pause), .read_row(read_row), .read_col(read_col),
        .cell_out(cell_out), .busy(busy)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // ------------------------------
    // compare tasks
    // ------------------------------
    task automatic compare_cell(input string name, input logic [hpp_pkg::CELL_W-1:0] expected,
                                input logic [hpp_pkg::CELL_W-1:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("** Error %s: expected %05b, actual %05b", name, expected, actual);
        end
    endtask

    task automatic compare_flag(input string name, input logic expected, input logic actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("** Error %s: expected %b, actual %b", name, expected, actual);
        end
    endtask

    task automatic compare_count(input string name, input int expected, input int actual);
        checks++;
        if (actual != expected) begin
            errors++;
            $display("** Error %s: expected %0d, actual %0d", name, expected, actual);
        end
    endtask

    // ------------------------------
    // drivers
    // ------------------------------
    task automatic apply_reset(input logic random_mode);
        @(negedge clk);
        reset       = 1'b0;
        fill_random = random_mode;      // sampled on the last reset cycle
        repeat (16) @(negedge clk);
        reset = 1'b1;
    endtask

    task automatic pulse_frame();
        @(negedge clk);
        frame_start = 1'b1;
        @(negedge clk);
        frame_start = 1'b0;
    endtask

    task automatic wait_idle(input string name);
        int cycles;
        cycles = 0;
        while (busy && cycles < WAIT_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if (busy) begin
            errors++;
            $display("%s: busy did not go low within %0d cycles", name, WAIT_LIMIT);
        end
    endtask

    task automatic read_site(input int r, input int c, output logic [hpp_pkg::CELL_W-1:0] value);
        @(negedge clk);
        read_row = ROW_W'(r);
        read_col = COL_W'(c);
        #2;                             // combinational readout settles
        value = cell_out;
    endtask

    task automatic check_grid(input string name);
        logic [hpp_pkg::CELL_W-1:0] value;
        for (int r = 0; r < ROWS; r++) begin
            for (int c = 0; c < COLS; c++) begin
                read_site(r, c, value);
                compare_cell($sformatf("%s r%0d c%0d", name, r, c), model_grid[r][c], value);
            end
        end
    endtask

    task automatic dut_particles(output int total);
        logic [hpp_pkg::CELL_W-1:0] value;
        total = 0;
        for (int r = 0; r < ROWS; r++) begin
            for (int c = 0; c < COLS; c++) begin
                read_site(r, c, value);
                total += $countones(value[3:0]);
            end
        end
    endtask

    // ------------------------------
    // tests
    // ------------------------------
    task automatic test_wall_fill();
        apply_reset(1'b0);
        compare_flag("wall_fill busy after reset", 1'b1, busy);
        wait_idle("wall_fill");
        model_fill(1'b0);
        check_grid("wall_fill");
    endtask

    task automatic test_random_fill();
        apply_reset(1'b1);
        compare_flag("random_fill busy after reset", 1'b1, busy);
        wait_idle("random_fill");
        model_fill(1'b1);
        check_grid("random_fill");
    endtask

    task automatic test_one_generation();
        pulse_frame();
        compare_flag("one_generation busy", 1'b1, busy);
        wait_idle("one_generation");
        model_generation();
        check_grid("one_generation");
    endtask

    task automatic test_five_generations();
        int expected;
        int actual;
        apply_reset(1'b1);
        wait_idle("five_generations fill");
        model_fill(1'b1);
        expected = model_particles();
        for (int g = 1; g <= 5; g++) begin
            pulse_frame();
            wait_idle($sformatf("five_generations gen %0d", g));
            model_generation();
            check_grid($sformatf("five_generations gen %0d", g));
            dut_particles(actual);
            compare_count($sformatf("five_generations count gen %0d", g), expected, actual);
        end
    endtask

    task automatic test_gating();
        logic [hpp_pkg::CELL_W-1:0] value;
        int                         r;
        int                         c;
        @(negedge clk);
        pause = 1'b1;
        pulse_frame();
        repeat (2 * COLS + 4) begin
            @(negedge clk);
            compare_flag("gating busy while paused", 1'b0, busy);
        end
        pause = 1'b0;
        for (int i = 0; i < 24; i++) begin      // grid untouched by the paused pulse
            r = int'((lcg_next() >> 16) % ROWS);
            c = int'((lcg_next() >> 16) % COLS);
            read_site(r, c, value);
            compare_cell($sformatf("gating paused r%0d c%0d", r, c), model_grid[r][c], value);
        end
        pulse_frame();
        pulse_frame();                          // lands in the collision sweep
        wait_idle("gating double pulse");
        model_generation();
        check_grid("gating double pulse");
    endtask

    initial begin
        errors      = 0;
        checks      = 0;
        reset       = 1'b0;
        fill_random = 1'b0;
        frame_start = 1'b0;
        pause       = 1'b0;
        read_row    = '0;
        read_col    = '0;

        test_wall_fill();
        test_random_fill();
        test_one_generation();
        test_five_generations();
        test_gating();

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== flist.f ====
+incdir+.
hpp_pkg.sv
hpp_control_fsm.sv
hpp_sweep_counter.sv
hpp_fill_source.sv
hpp_row_pe.sv
hpp_automaton.sv
tb_hpp_automaton.sv

// ==== Makefile ====
# Verilator build and run of the HPP engine testbench

VERILATOR ?= verilator
TOP       ?= tb_hpp_automaton
LINT_TOP  ?= hpp_automaton
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Finished with no errors
VFLAGS    ?= --binary --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: build
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "simulation FAILED, see $(LOG)"; exit 1; }
	@echo "simulation passed"

lint:
	$(VERILATOR) --lint-only --timing -Wall --top-module $(LINT_TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
